//--- compile.f
hw/masku_pkg.sv
hw/masku_insn_ctrl.sv
hw/masku_merge.sv
hw/masku_result_queue.sv
hw/masku.sv
tb/masku_sva.sv
tb/tb_masku.sv

//--- Makefile
# Verilator build and run of the mask unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_masku -f compile.f
	./obj_dir/Vtb_masku +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- tb/tb_masku.sv
////////////////////
// Directed testbench of the mask unit
// Drives instructions and lane operands, grants lane writes and
// compares each written word with a model of the merge rule
////////////////////

module tb_masku;

  timeunit 1ns;
  timeprecision 100ps;

  import masku_pkg::*;

  // Cycle limit of every wait loop
  localparam int TIMEOUT   = 300;
  localparam int MAX_BEATS = 4;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_valid_i;
  vid_t                 req_id_i;
  vlen_t                req_vl_i;
  vaddr_t               req_vd_i;
  logic                 req_vm_i;
  logic                 req_ready_o;
  elen_t [NR_LANES-1:0] opa_i;
  elen_t [NR_LANES-1:0] opb_i;
  elen_t [NR_LANES-1:0] opm_i;
  logic  [NR_LANES-1:0] opa_valid_i;
  logic  [NR_LANES-1:0] opb_valid_i;
  logic  [NR_LANES-1:0] opm_valid_i;
  logic  [NR_LANES-1:0] op_ready_o;
  logic  [NR_LANES-1:0] res_req_o;
  vid_t  [NR_LANES-1:0] res_id_o;
  vaddr_t [NR_LANES-1:0] res_addr_o;
  elen_t [NR_LANES-1:0] res_wdata_o;
  strb_t [NR_LANES-1:0] res_be_o;
  logic  [NR_LANES-1:0] res_gnt_i;
  logic                 done_o;
  vid_t                 done_id_o;

  int unsigned mismatch_cnt;
  int unsigned other_cnt;
  int unsigned timeout_cnt;
  int unsigned error_total;

  // Operands of each beat of the running instruction
  elen_t [NR_LANES-1:0] beat_a [MAX_BEATS];
  elen_t [NR_LANES-1:0] beat_b [MAX_BEATS];
  elen_t [NR_LANES-1:0] beat_m [MAX_BEATS];
  // Expected write data and strobes per beat
  elen_t [NR_LANES-1:0] exp_data [MAX_BEATS];
  strb_t [NR_LANES-1:0] exp_be [MAX_BEATS];

  masku UUT (.*);

  bind masku masku_sva sva_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .res_req_i  (res_req_o),
    .res_gnt_i  (res_gnt_i),
    .done_i     (done_o),
    .op_ready_i (op_ready_o),
    .full_i     (q_full)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Reference for beat n: bits below the beat length take a where enabled
  function automatic void build_expect(int vl, logic vm, int n);
    int len;
    int k;
    len = vl - n * BEAT_BITS;
    if (len > BEAT_BITS) begin
      len = BEAT_BITS;
    end
    for (int l = 0; l < NR_LANES; l++) begin
      for (int i = 0; i < ELEN; i++) begin
        k = l * ELEN + i;
        exp_data[n][l][i] = ((k < len) && (vm || beat_m[n][l][i])) ? beat_a[n][l][i]
                                                                    : beat_b[n][l][i];
      end
      // A byte is written if any of its bits lies inside the length
      for (int j = 0; j < STRB_W; j++) begin
        exp_be[n][l][j] = ((l * STRB_W + j) * 8 < len);
      end
    end
  endfunction

  task automatic check_word(string name, elen_t exp, elen_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_strb(string name, strb_t exp, strb_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, vaddr_t exp, vaddr_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_id(string name, vid_t exp, vid_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic drive_beat(int n, logic valid);
    opa_i       = beat_a[n];
    opb_i       = beat_b[n];
    opm_i       = beat_m[n];
    opa_valid_i = {NR_LANES{valid}};
    opb_valid_i = {NR_LANES{valid}};
    opm_valid_i = {NR_LANES{valid}};
  endtask

  // No write, no done and a free slot for the given number of cycles
  task automatic check_idle(string name, int ncycles);
    repeat (ncycles) begin
      @(negedge clk_i);
      if (!req_ready_o || (res_req_o != '0) || done_o || (op_ready_o != '0)) begin
        other_cnt++;
        $display("error in %s: unit not idle, req_ready_o=%b res_req_o=%b done_o=%b",
                 name, req_ready_o, res_req_o, done_o);
      end
    end
  endtask

  // One instruction end to end; the last lane's grant is withheld for hold cycles
  task automatic run_insn(string name, vid_t id, int vl, vaddr_t vd, logic vm, int hold);
    int  nbeats;
    int  fired;
    int  total;
    int  cycles;
    int  pending;
    int  got [NR_LANES];
    logic fire;
    logic done_seen;
    logic saw_full;
    if (timeout_cnt != 0) begin
      return;
    end
    nbeats = (vl + BEAT_BITS - 1) / BEAT_BITS;
    for (int n = 0; n < nbeats; n++) begin
      for (int l = 0; l < NR_LANES; l++) begin
        beat_a[n][l] = {$urandom, $urandom};
        beat_b[n][l] = {$urandom, $urandom};
        beat_m[n][l] = {$urandom, $urandom};
      end
      build_expect(vl, vm, n);
    end
    for (int l = 0; l < NR_LANES; l++) begin
      got[l] = 0;
    end
    fired     = 0;
    total     = 0;
    cycles    = 0;
    done_seen = 1'b0;
    saw_full  = 1'b0;

    // Present the instruction and the first beat together
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b1;
    req_id_i    = id;
    req_vl_i    = vlen_t'(vl);
    req_vd_i    = vd;
    req_vm_i    = vm;
    drive_beat(0, 1'b1);
    res_gnt_i   = (hold > 0) ? {1'b0, {(NR_LANES-1){1'b1}}} : '1;

    @(negedge clk_i);
    while (!req_ready_o) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        timeout_cnt++;
        $display("timeout in %s: instruction never accepted", name);
        return;
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;

    cycles = 0;
    while (!done_seen || (total < nbeats * NR_LANES)) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        timeout_cnt++;
        $display("timeout in %s: results or done did not arrive", name);
        return;
      end
      fire    = op_ready_o[0];
      pending = fired - got[NR_LANES-1];
      if (pending == RESULT_DEPTH) begin
        saw_full = 1'b1;
      end
      if (op_ready_o != {NR_LANES{fire}}) begin
        other_cnt++;
        $display("error in %s: lanes disagree on op_ready_o %b", name, op_ready_o);
      end
      if (fire && ((pending >= RESULT_DEPTH) || (fired >= nbeats))) begin
        other_cnt++;
        $display("error in %s: operands taken with %0d entries pending", name, pending);
      end
      // Every granted lane write is compared with the next beat of that lane
      for (int l = 0; l < NR_LANES; l++) begin
        if (res_req_o[l] && res_gnt_i[l]) begin
          if (got[l] >= nbeats) begin
            other_cnt++;
            $display("error in %s: extra write on lane %0d", name, l);
          end else begin
            check_word(name, exp_data[got[l]][l], res_wdata_o[l]);
            check_strb(name, exp_be[got[l]][l], res_be_o[l]);
            check_addr(name, vaddr_t'(vd + got[l]), res_addr_o[l]);
            check_id(name, id, res_id_o[l]);
          end
          got[l]++;
          total++;
        end
      end
      if (done_o) begin
        check_id(name, id, done_id_o);
        if (done_seen || (total < nbeats * NR_LANES) || !req_ready_o) begin
          other_cnt++;
          $display("error in %s: done repeated, early or without req_ready_o", name);
        end
        done_seen = 1'b1;
      end
      @(posedge clk_i);
      #1;
      if (fire) begin
        fired++;
      end
      // Operands keep coming until every beat is taken
      drive_beat((fired < nbeats) ? fired : 0, fired < nbeats);
      if (cycles >= hold) begin
        res_gnt_i = '1;
      end
    end
    res_gnt_i = '0;
    if ((hold > 0) && !saw_full) begin
      other_cnt++;
      $display("error in %s: result queue never filled under back-pressure", name);
    end
    check_idle(name, 3);
  endtask

  initial begin
    void'($urandom(32'h72040da8));
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_id_i     = '0;
    req_vl_i     = '0;
    req_vd_i     = '0;
    req_vm_i     = 1'b0;
    opa_i        = '0;
    opb_i        = '0;
    opm_i        = '0;
    opa_valid_i  = '0;
    opb_valid_i  = '0;
    opm_valid_i  = '0;
    res_gnt_i    = '0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    timeout_cnt  = 0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    check_idle("reset", 10);
    run_insn("unmasked_vl100", 3'd1, 100, 16'h0040, 1'b1, 0);
    run_insn("masked_vl256", 3'd2, 256, 16'h0100, 1'b0, 0);
    // 600 bits, the third beat keeps 88
    run_insn("multi_vl600", 3'd5, 600, 16'h0200, 1'b1, 0);
    run_insn("backpressure", 3'd6, 1000, 16'h0300, 1'b0, 20);

    error_total = mismatch_cnt + other_cnt + timeout_cnt + UUT.sva_i.fail_cnt;
    $display("errors: mismatch %0d, protocol %0d, timeout %0d, assertion %0d",
             mismatch_cnt, other_cnt, timeout_cnt, UUT.sva_i.fail_cnt);
    if (error_total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- tb/masku_sva.sv
////////////////////
// Protocol assertions for the mask unit bound into the top level
// Lane requests hold until granted and done is a single pulse
// No operands are taken while the result queue is full
////////////////////

module masku_sva (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic [masku_pkg::NR_LANES-1:0]     res_req_i,
  input logic [masku_pkg::NR_LANES-1:0]     res_gnt_i,
  input logic                               done_i,
  input logic [masku_pkg::NR_LANES-1:0]     op_ready_i,
  input logic                               full_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertion count
  int unsigned fail_cnt = 0;

  // Every lane that asked and got no grant still asks one cycle later
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((res_req_i & $past(res_req_i & ~res_gnt_i)) == $past(res_req_i & ~res_gnt_i)))
    else begin
      fail_cnt++;
      $error("lane request dropped before its grant");
    end

  // Done lasts exactly one cycle
  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done held high for two cycles");
    end

  // A full queue stalls the operand side
  full_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_i |-> (op_ready_i == '0))
    else begin
      fail_cnt++;
      $error("operands taken while the result queue is full");
    end

endmodule

//--- hw/masku.sv
////////////////////
// Mask-logical unit top level
// Takes one instruction from the sequencer, merges lane operands per beat
// and writes the results back to the lanes
////////////////////

module masku (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Sequencer
  input  logic                                        req_valid_i,
  input  masku_pkg::vid_t                             req_id_i,
  input  masku_pkg::vlen_t                            req_vl_i,
  input  masku_pkg::vaddr_t                           req_vd_i,
  input  logic                                        req_vm_i,
  output logic                                        req_ready_o,
  // Lane operands
  input  masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] opa_i,
  input  logic              [masku_pkg::NR_LANES-1:0] opa_valid_i,
  input  masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] opb_i,
  input  logic              [masku_pkg::NR_LANES-1:0] opb_valid_i,
  input  masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] opm_i,
  input  logic              [masku_pkg::NR_LANES-1:0] opm_valid_i,
  output logic              [masku_pkg::NR_LANES-1:0] op_ready_o,
  // Lane result writes
  output logic              [masku_pkg::NR_LANES-1:0] res_req_o,
  output masku_pkg::vid_t   [masku_pkg::NR_LANES-1:0] res_id_o,
  output masku_pkg::vaddr_t [masku_pkg::NR_LANES-1:0] res_addr_o,
  output masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] res_wdata_o,
  output masku_pkg::strb_t  [masku_pkg::NR_LANES-1:0] res_be_o,
  input  logic              [masku_pkg::NR_LANES-1:0] res_gnt_i,
  // Completion
  output logic                                        done_o,
  output masku_pkg::vid_t                             done_id_o
);

  import masku_pkg::*;

  logic                 issue_valid;
  logic                 vm;
  vlen_t                remain;
  vaddr_t               beat_addr;
  vid_t                 insn_id;
  logic                 q_full;
  logic                 q_retire;
  logic                 beat_fire;
  elen_t [NR_LANES-1:0] merged;
  strb_t [NR_LANES-1:0] merged_be;

  // All three operands of every lane arrive together
  // m is ignored for unmasked instructions
  assign beat_fire = issue_valid && (&opa_valid_i) && (&opb_valid_i) &&
                     (vm || (&opm_valid_i)) && !q_full;

  // Operands are consumed in lockstep across lanes
  assign op_ready_o = {NR_LANES{beat_fire}};

  masku_insn_ctrl i_insn_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_id_i       (req_id_i),
    .req_vl_i       (req_vl_i),
    .req_vd_i       (req_vd_i),
    .req_vm_i       (req_vm_i),
    .req_ready_o    (req_ready_o),
    .beat_fire_i    (beat_fire),
    .entry_retire_i (q_retire),
    .issue_valid_o  (issue_valid),
    .vm_o           (vm),
    .remain_o       (remain),
    .beat_addr_o    (beat_addr),
    .id_o           (insn_id),
    .done_o         (done_o),
    .done_id_o      (done_id_o)
  );

  masku_merge i_merge (
    .remain_i (remain),
    .vm_i     (vm),
    .opa_i    (opa_i),
    .opb_i    (opb_i),
    .opm_i    (opm_i),
    .wdata_o  (merged),
    .be_o     (merged_be)
  );

  masku_result_queue i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (beat_fire),
    .push_id_i    (insn_id),
    .push_addr_i  (beat_addr),
    .push_wdata_i (merged),
    .push_be_i    (merged_be),
    .full_o       (q_full),
    .retire_o     (q_retire),
    .res_req_o    (res_req_o),
    .res_gnt_i    (res_gnt_i),
    .res_id_o     (res_id_o),
    .res_addr_o   (res_addr_o),
    .res_wdata_o  (res_wdata_o),
    .res_be_o     (res_be_o)
  );

endmodule

//--- hw/masku_result_queue.sv
////////////////////
// Per-lane write-request queue of the mask unit
// Each entry is offered to all lanes at once; lanes grant independently
// and the entry retires once every lane has taken it
////////////////////

module masku_result_queue (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Write side
  input  logic                                        push_i,
  input  masku_pkg::vid_t                             push_id_i,
  input  masku_pkg::vaddr_t                           push_addr_i,
  input  masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] push_wdata_i,
  input  masku_pkg::strb_t  [masku_pkg::NR_LANES-1:0] push_be_i,
  output logic                                        full_o,
  output logic                                        retire_o,
  // Lane write interface
  output logic              [masku_pkg::NR_LANES-1:0] res_req_o,
  input  logic              [masku_pkg::NR_LANES-1:0] res_gnt_i,
  output masku_pkg::vid_t   [masku_pkg::NR_LANES-1:0] res_id_o,
  output masku_pkg::vaddr_t [masku_pkg::NR_LANES-1:0] res_addr_o,
  output masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] res_wdata_o,
  output masku_pkg::strb_t  [masku_pkg::NR_LANES-1:0] res_be_o
);

  import masku_pkg::*;

  // Entry payload, no reset needed
  vid_t                 id_q    [RESULT_DEPTH];
  vaddr_t               addr_q  [RESULT_DEPTH];
  elen_t [NR_LANES-1:0] wdata_q [RESULT_DEPTH];
  strb_t [NR_LANES-1:0] be_q    [RESULT_DEPTH];

  // Outstanding lane requests per entry
  logic [RESULT_DEPTH-1:0][NR_LANES-1:0] valid_q, valid_d;
  // Ring pointers and occupancy
  logic [RQ_PTR_W-1:0] wr_ptr_q;
  logic [RQ_PTR_W-1:0] rd_ptr_q;
  logic [RQ_CNT_W-1:0] cnt_q;

  logic                empty;
  logic [NR_LANES-1:0] head_left;

  assign empty  = (cnt_q == '0);
  assign full_o = (cnt_q == RQ_CNT_W'(RESULT_DEPTH));

  // Lanes of the head entry still waiting after this cycle's grants
  assign head_left = valid_q[rd_ptr_q] & ~res_gnt_i;
  assign retire_o  = !empty && (head_left == '0);

  always_comb begin
    valid_d           = valid_q;
    valid_d[rd_ptr_q] = head_left;
    // Never collides with the head, since push needs a free slot
    if (push_i) begin
      valid_d[wr_ptr_q] = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == RQ_PTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (retire_o) begin
        rd_ptr_q <= (rd_ptr_q == RQ_PTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy follows push and pop together
      case ({push_i, retire_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[wr_ptr_q]    <= push_id_i;
      addr_q[wr_ptr_q]  <= push_addr_i;
      wdata_q[wr_ptr_q] <= push_wdata_i;
      be_q[wr_ptr_q]    <= push_be_i;
    end
  end

  // Head entry drives every lane, id and address are common to all
  assign res_req_o   = valid_q[rd_ptr_q];
  assign res_id_o    = {NR_LANES{id_q[rd_ptr_q]}};
  assign res_addr_o  = {NR_LANES{addr_q[rd_ptr_q]}};
  assign res_wdata_o = wdata_q[rd_ptr_q];
  assign res_be_o    = be_q[rd_ptr_q];

endmodule

//--- hw/masku_merge.sv
////////////////////
// Bit-level merge for one beat
// Tail and mask build a bit enable; a is taken where set, b elsewhere
////////////////////

module masku_merge (
  input  masku_pkg::vlen_t                           remain_i,
  input  logic                                       vm_i,
  input  masku_pkg::elen_t [masku_pkg::NR_LANES-1:0] opa_i,
  input  masku_pkg::elen_t [masku_pkg::NR_LANES-1:0] opb_i,
  input  masku_pkg::elen_t [masku_pkg::NR_LANES-1:0] opm_i,
  output masku_pkg::elen_t [masku_pkg::NR_LANES-1:0] wdata_o,
  output masku_pkg::strb_t [masku_pkg::NR_LANES-1:0] be_o
);

  import masku_pkg::*;

  // Flat views, bit k lives in lane k/64 at offset k%64
  logic [BEAT_BITS-1:0]      a_flat;
  logic [BEAT_BITS-1:0]      b_flat;
  logic [BEAT_BITS-1:0]      m_flat;
  logic [BEAT_BITS-1:0]      bit_en;
  logic [NR_LANES*STRB_W-1:0] byte_en;
  // Bits and bytes of this beat that lie inside vl
  logic [BEAT_LEN_W-1:0]     beat_len;
  logic [BEAT_LEN_W-1:0]     beat_bytes;

  assign a_flat = opa_i;
  assign b_flat = opb_i;
  assign m_flat = opm_i;

  // Clip the remaining length to one beat
  assign beat_len   = (remain_i >= vlen_t'(BEAT_BITS)) ? BEAT_LEN_W'(BEAT_BITS)
                                                       : remain_i[BEAT_LEN_W-1:0];
  // Partially covered bytes are still strobed
  assign beat_bytes = (beat_len + BEAT_LEN_W'(7)) >> 3;

  always_comb begin
    bit_en = '0;
    for (int unsigned k = 0; k < BEAT_BITS; k++) begin
      bit_en[k] = (k < beat_len);
    end
    // Masked instruction, m gates the tail enable
    if (!vm_i) begin
      bit_en = bit_en & m_flat;
    end
  end

  always_comb begin
    byte_en = '0;
    for (int unsigned j = 0; j < NR_LANES * STRB_W; j++) begin
      byte_en[j] = (j < beat_bytes);
    end
  end

  // Old destination value survives where the enable is clear
  assign wdata_o = (a_flat & bit_en) | (b_flat & ~bit_en);
  assign be_o    = byte_en;

endmodule

//--- hw/masku_insn_ctrl.sv
////////////////////
// Instruction slot of the mask unit
// Holds one instruction, counts issued and committed bits,
// produces the beat address and the done pulse with the id
////////////////////

module masku_insn_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sequencer handshake
  input  logic               req_valid_i,
  input  masku_pkg::vid_t    req_id_i,
  input  masku_pkg::vlen_t   req_vl_i,
  input  masku_pkg::vaddr_t  req_vd_i,
  input  logic               req_vm_i,
  output logic               req_ready_o,
  // Progress events from the datapath
  input  logic               beat_fire_i,
  input  logic               entry_retire_i,
  // State of the held instruction
  output logic               issue_valid_o,
  output logic               vm_o,
  output masku_pkg::vlen_t   remain_o,
  output masku_pkg::vaddr_t  beat_addr_o,
  output masku_pkg::vid_t    id_o,
  // Completion
  output logic               done_o,
  output masku_pkg::vid_t    done_id_o
);

  import masku_pkg::*;

  // Beat size in the counter width
  localparam vlen_t BEAT_VL = vlen_t'(BEAT_BITS);

  // Slot occupancy and completion pulse
  logic   held_q;
  logic   done_q;
  // Bits still to be issued and still to be written back
  vlen_t  issue_cnt_q;
  vlen_t  commit_cnt_q;
  // Beat index from the start of the instruction
  vaddr_t beat_idx_q;
  // Instruction fields
  vid_t   id_q;
  vaddr_t vd_q;
  logic   vm_q;

  logic   accept;
  logic   last_retire;

  // Zero-length instructions are never taken
  assign accept      = req_valid_i && !held_q && (req_vl_i != '0);
  // The final entry of this instruction leaves the result queue
  assign last_retire = held_q && entry_retire_i && (commit_cnt_q <= BEAT_VL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q       <= 1'b0;
      done_q       <= 1'b0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      beat_idx_q   <= '0;
    end else begin
      done_q <= last_retire;
      if (accept) begin
        held_q       <= 1'b1;
        issue_cnt_q  <= req_vl_i;
        commit_cnt_q <= req_vl_i;
        beat_idx_q   <= '0;
      end else begin
        // Issue side, saturating at zero
        if (beat_fire_i) begin
          issue_cnt_q <= (issue_cnt_q > BEAT_VL) ? issue_cnt_q - BEAT_VL : '0;
          beat_idx_q  <= beat_idx_q + vaddr_t'(1);
        end
        // Commit side, saturating at zero
        if (held_q && entry_retire_i) begin
          commit_cnt_q <= (commit_cnt_q > BEAT_VL) ? commit_cnt_q - BEAT_VL : '0;
        end
        // Free the slot once everything is written
        if (last_retire) begin
          held_q <= 1'b0;
        end
      end
    end
  end

  // Instruction fields only change on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q <= req_id_i;
      vd_q <= req_vd_i;
      vm_q <= req_vm_i;
    end
  end

  assign req_ready_o   = !held_q;
  assign issue_valid_o = held_q && (issue_cnt_q != '0);
  assign vm_o          = vm_q;
  assign remain_o      = issue_cnt_q;
  // One register-file word per beat
  assign beat_addr_o   = vd_q + beat_idx_q;
  assign id_o          = id_q;

  // Id stays stable until the next accept, which is after the pulse
  assign done_o    = done_q;
  assign done_id_o = id_q;

endmodule

//--- hw/masku_pkg.sv
////////////////////
// Shared widths, types and queue sizing for the mask-logical unit
// Imported by every RTL block and by the testbench
////////////////////

package masku_pkg;

  // Lane count and lane datapath width
  localparam int unsigned NR_LANES = 4;
  localparam int unsigned ELEN     = 64;

  // One beat spans all lanes
  localparam int unsigned BEAT_BITS = NR_LANES * ELEN;

  // Byte strobes per lane word
  localparam int unsigned STRB_W = ELEN / 8;

  // Result queue sizing
  localparam int unsigned RESULT_DEPTH = 2;
  // Pointer and occupancy widths of the result queue
  localparam int unsigned RQ_PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
  localparam int unsigned RQ_CNT_W = $clog2(RESULT_DEPTH + 1);

  // Beat length field wide enough to hold BEAT_BITS itself
  localparam int unsigned BEAT_LEN_W = $clog2(BEAT_BITS + 1);

  // Widths of the instruction fields
  localparam int unsigned VID_W   = 3;
  localparam int unsigned VADDR_W = 16;
  localparam int unsigned VLEN_W  = 16;

  // One lane data word
  typedef logic [ELEN-1:0] elen_t;

  // Byte strobes of one lane word
  typedef logic [STRB_W-1:0] strb_t;

  // Instruction id as issued by the sequencer
  typedef logic [VID_W-1:0] vid_t;

  // Word address in the vector register file
  typedef logic [VADDR_W-1:0] vaddr_t;

  // Length of an instruction in bits
  typedef logic [VLEN_W-1:0] vlen_t;

endpackage
